/* common/sdram_cache_pkg.sv */
// sdram cache package
// geometry, address split, tag word layout, controller commands,
// timing constants and sequencer state codes
`default_nettype none

package sdram_cache_pkg;

  // 8 words per line, 64 lines
  localparam int COL_BITS = 3;
  localparam int COL_COUNT = 8;
  localparam int LINE_BITS = 6;
  localparam int LINE_COUNT = 64;

  // word addressed controller, tag is what is left above line and column
  localparam int SDRAM_ADDR_BITS = 21;
  localparam int TAG_BITS = SDRAM_ADDR_BITS - LINE_BITS - COL_BITS;

  // processor byte address |tag|line|col|00|
  localparam int COL_LSB = 2;
  localparam int LINE_LSB = COL_LSB + COL_BITS;
  localparam int TAG_LSB = LINE_LSB + LINE_BITS;

  // flags stored just above the tag
  localparam int VALID_BIT = 12;
  localparam int DIRTY_BIT = 13;

  // controller commands
  localparam logic [2:0] CMD_REFRESH = 3'b001;
  localparam logic [2:0] CMD_ACTIVATE = 3'b011;
  localparam logic [2:0] CMD_WRITE = 3'b100;
  localparam logic [2:0] CMD_READ = 3'b101;

  // cycles after the read command cycle before the first word, CL=2
  localparam logic [2:0] READ_WAIT = 3'd4;
  localparam logic [9:0] REFRESH_PERIOD = 10'd600;
  localparam logic [7:0] BURST_LEN = 8'(COL_COUNT - 1);

  // sequencer states
  localparam logic [3:0] ST_INIT_REFRESH = 4'd0;
  localparam logic [3:0] ST_IDLE = 4'd1;
  localparam logic [3:0] ST_REFRESH = 4'd2;
  localparam logic [3:0] ST_EVICT_ACT = 4'd3;
  localparam logic [3:0] ST_EVICT_STREAM = 4'd4;
  localparam logic [3:0] ST_EVICT_DONE = 4'd5;
  localparam logic [3:0] ST_FILL_ACT = 4'd6;
  localparam logic [3:0] ST_FILL_WAIT = 4'd7;
  localparam logic [3:0] ST_FILL_STREAM = 4'd8;
  localparam logic [3:0] ST_TAG_COMMIT = 4'd9;

endpackage

`default_nettype wire

/* logic/bram_byte.sv */
// single port block ram, one word per cache line
// per byte write enables, registered write-first read
`timescale 1ns/1ps
`default_nettype none

module bram_byte (
  input wire clk,
  input wire [3:0] write_enable,
  input wire [sdram_cache_pkg::LINE_BITS-1:0] address,
  input wire [31:0] data_in,
  output logic [31:0] data_out
);

  logic [31:0] mem [sdram_cache_pkg::LINE_COUNT];

  // ram powers up cleared so every tag starts out invalid
  initial begin
    for (int i = 0; i < sdram_cache_pkg::LINE_COUNT; i++) begin
      mem[i] = '0;
    end
  end

  always @(posedge clk) begin
    for (int i = 0; i < 4; i++) begin
      if (write_enable[i]) begin
        mem[address][8*i+:8] <= data_in[8*i+:8];
      end
      // written bytes show up on the output in the next cycle
      data_out[8*i+:8] <= write_enable[i] ? data_in[8*i+:8] : mem[address][8*i+:8];
    end
  end

endmodule

`default_nettype wire

/* logic/tag_store.sv */
// cache tag store
// one tag word per line holding tag, valid and dirty flags;
// decodes hit, busy and data_out_ready for the processor side
`timescale 1ns/1ps
`default_nettype none

module tag_store (
  input wire clk,
  input wire enable,
  input wire [31:0] address,
  input wire [3:0] write_enable,
  input wire filling,
  input wire tag_fill_we,
  output logic hit,
  output logic line_dirty,
  output logic [sdram_cache_pkg::TAG_BITS-1:0] cached_tag,
  output logic cpu_write_hit,
  output logic busy,
  output logic data_out_ready
);

  wire [sdram_cache_pkg::LINE_BITS-1:0] line_ix =
    address[sdram_cache_pkg::LINE_LSB+:sdram_cache_pkg::LINE_BITS];
  wire [sdram_cache_pkg::TAG_BITS-1:0] addr_tag =
    address[sdram_cache_pkg::TAG_LSB+:sdram_cache_pkg::TAG_BITS];

  logic [sdram_cache_pkg::LINE_BITS-1:0] line_q;
  logic [31:0] tag_word;
  logic [3:0] tag_we;
  logic [31:0] tag_wdata;

  // ram output belongs to the line read in the previous cycle
  always_ff @(posedge clk) begin
    line_q <= line_ix;
  end

  wire line_valid = tag_word[sdram_cache_pkg::VALID_BIT];
  assign cached_tag = tag_word[sdram_cache_pkg::TAG_BITS-1:0];
  assign line_dirty = line_valid && tag_word[sdram_cache_pkg::DIRTY_BIT];

  // no hit on the first cycle of a new line, the ram has not caught up yet
  assign hit = line_valid && cached_tag == addr_tag && line_q == line_ix;
  assign busy = enable && !hit;
  assign data_out_ready = enable && hit && write_enable == 4'b0000;
  assign cpu_write_hit = enable && hit && write_enable != 4'b0000 && !filling;

  always_comb begin
    tag_we = 4'b0000;
    tag_wdata = '0;
    tag_wdata[sdram_cache_pkg::TAG_BITS-1:0] = addr_tag;
    if (tag_fill_we) begin
      // freshly filled line, valid and clean
      tag_we = 4'b1111;
      tag_wdata[sdram_cache_pkg::VALID_BIT] = 1'b1;
    end else if (cpu_write_hit) begin
      // write hit marks the line dirty
      tag_we = 4'b1111;
      tag_wdata[sdram_cache_pkg::VALID_BIT] = 1'b1;
      tag_wdata[sdram_cache_pkg::DIRTY_BIT] = 1'b1;
    end
  end

  bram_byte u_tag_ram (
    .clk(clk),
    .write_enable(tag_we),
    .address(line_ix),
    .data_in(tag_wdata),
    .data_out(tag_word)
  );

  // the sequencer only commits a tag at the end of a fill
  a_tag_fill_in_fill: assert property (@(posedge clk) tag_fill_we |-> filling);

endmodule

`default_nettype wire

/* logic/line_store.sv */
// cache line data store
// eight column rams side by side on the line index; processor write
// hits and line fills share the write ports, two read muxes
`timescale 1ns/1ps
`default_nettype none

module line_store (
  input wire clk,
  input wire [31:0] address,
  input wire [31:0] data_in,
  input wire [3:0] write_enable,
  input wire cpu_write_hit,
  input wire filling,
  input wire [sdram_cache_pkg::COL_COUNT-1:0] fill_col_we,
  input wire [31:0] fill_word,
  input wire [sdram_cache_pkg::COL_BITS-1:0] evict_col,
  output logic [31:0] data_out,
  output logic [31:0] evict_word
);

  wire [sdram_cache_pkg::COL_BITS-1:0] col_ix =
    address[sdram_cache_pkg::COL_LSB+:sdram_cache_pkg::COL_BITS];
  wire [sdram_cache_pkg::LINE_BITS-1:0] line_ix =
    address[sdram_cache_pkg::LINE_LSB+:sdram_cache_pkg::LINE_BITS];

  logic [31:0] col_out [sdram_cache_pkg::COL_COUNT];
  logic [sdram_cache_pkg::COL_COUNT-1:0] cpu_col_sel;

  // one hot select of the column hit by a processor write
  always_comb begin
    cpu_col_sel = '0;
    cpu_col_sel[col_ix] = cpu_write_hit;
  end

  for (genvar i = 0; i < sdram_cache_pkg::COL_COUNT; i++) begin : g_col
    logic [3:0] col_we;

    // fill owns the write ports for the whole miss
    always_comb begin
      if (filling) begin
        col_we = {4{fill_col_we[i]}};
      end else if (cpu_col_sel[i]) begin
        col_we = write_enable;
      end else begin
        col_we = 4'b0000;
      end
    end

    bram_byte u_col_ram (
      .clk(clk),
      .write_enable(col_we),
      .address(line_ix),
      .data_in(filling ? fill_word : data_in),
      .data_out(col_out[i])
    );
  end

  assign data_out = col_out[col_ix];
  // eviction walks the columns of the same line
  assign evict_word = col_out[evict_col];

  // fill writes one column per cycle
  a_fill_one_col: assert property (@(posedge clk) $onehot0(fill_col_we));

endmodule

`default_nettype wire

/* sdram_seq/sdram_seq.sv */
// sdram sequencer for the cache
// issues the refresh after reset and periodic refreshes while idle,
// writes back a dirty victim line and fills the missing line
`timescale 1ns/1ps
`default_nettype none

module sdram_seq (
  input wire clk,
  input wire rst_n,
  input wire enable,
  input wire [31:0] address,
  input wire hit,
  input wire line_dirty,
  input wire [sdram_cache_pkg::TAG_BITS-1:0] cached_tag,
  input wire [31:0] evict_word,
  input wire [31:0] sdrc_data_out,
  input wire sdrc_cmd_ack,
  output logic filling,
  output logic [sdram_cache_pkg::COL_COUNT-1:0] fill_col_we,
  output logic [31:0] fill_word,
  output logic tag_fill_we,
  output logic [sdram_cache_pkg::COL_BITS-1:0] evict_col,
  output logic sdrc_cmd_en,
  output logic [2:0] sdrc_cmd,
  output logic [sdram_cache_pkg::SDRAM_ADDR_BITS-1:0] sdrc_addr,
  output logic [7:0] sdrc_data_len,
  output logic [31:0] sdrc_data_in
);

  wire [sdram_cache_pkg::LINE_BITS-1:0] line_ix =
    address[sdram_cache_pkg::LINE_LSB+:sdram_cache_pkg::LINE_BITS];
  wire [sdram_cache_pkg::TAG_BITS-1:0] addr_tag =
    address[sdram_cache_pkg::TAG_LSB+:sdram_cache_pkg::TAG_BITS];

  // line start addresses, column bits zero
  wire [sdram_cache_pkg::SDRAM_ADDR_BITS-1:0] victim_addr =
    {cached_tag, line_ix, {sdram_cache_pkg::COL_BITS{1'b0}}};
  wire [sdram_cache_pkg::SDRAM_ADDR_BITS-1:0] fill_addr =
    {addr_tag, line_ix, {sdram_cache_pkg::COL_BITS{1'b0}}};

  logic [3:0] state;
  logic [sdram_cache_pkg::LINE_BITS-1:0] line_q;
  logic cmd_pending;
  logic [9:0] idle_cnt;
  logic [2:0] wait_cnt;
  logic [sdram_cache_pkg::COL_BITS-1:0] col;

  // previous command acked, now or earlier
  wire cmd_done = !sdrc_cmd_en && (!cmd_pending || sdrc_cmd_ack);
  // only trust a miss once the tag ram shows the current line
  wire miss = enable && !hit && line_ix == line_q;

  assign filling = state == sdram_cache_pkg::ST_FILL_ACT ||
                   state == sdram_cache_pkg::ST_FILL_WAIT ||
                   state == sdram_cache_pkg::ST_FILL_STREAM ||
                   state == sdram_cache_pkg::ST_TAG_COMMIT;
  assign tag_fill_we = state == sdram_cache_pkg::ST_TAG_COMMIT;
  assign fill_word = sdrc_data_out;
  assign evict_col = col;
  // write data follows the column counter, col 0 in the command cycle
  assign sdrc_data_in = evict_word;

  always_comb begin
    fill_col_we = '0;
    if (state == sdram_cache_pkg::ST_FILL_STREAM) begin
      fill_col_we[col] = 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    line_q <= line_ix;
  end

  // set by a command pulse, cleared by its ack
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      cmd_pending <= 1'b0;
    end else if (sdrc_cmd_en) begin
      cmd_pending <= 1'b1;
    end else if (sdrc_cmd_ack) begin
      cmd_pending <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= sdram_cache_pkg::ST_INIT_REFRESH;
      sdrc_cmd_en <= 1'b0;
      idle_cnt <= '0;
      wait_cnt <= '0;
      col <= '0;
    end else begin
      // commands are single cycle pulses
      sdrc_cmd_en <= 1'b0;
      case (state)
        sdram_cache_pkg::ST_INIT_REFRESH: begin
          sdrc_cmd_en <= 1'b1;
          sdrc_cmd <= sdram_cache_pkg::CMD_REFRESH;
          sdrc_addr <= '0;
          sdrc_data_len <= '0;
          state <= sdram_cache_pkg::ST_REFRESH;
        end
        sdram_cache_pkg::ST_IDLE: begin
          idle_cnt <= idle_cnt + 1'b1;
          if (cmd_done) begin
            // refresh wins over a pending miss
            if (idle_cnt > sdram_cache_pkg::REFRESH_PERIOD) begin
              sdrc_cmd_en <= 1'b1;
              sdrc_cmd <= sdram_cache_pkg::CMD_REFRESH;
              sdrc_addr <= '0;
              sdrc_data_len <= '0;
              state <= sdram_cache_pkg::ST_REFRESH;
            end else if (miss) begin
              sdrc_cmd_en <= 1'b1;
              sdrc_cmd <= sdram_cache_pkg::CMD_ACTIVATE;
              sdrc_data_len <= '0;
              if (line_dirty) begin
                sdrc_addr <= victim_addr;
                state <= sdram_cache_pkg::ST_EVICT_ACT;
              end else begin
                sdrc_addr <= fill_addr;
                state <= sdram_cache_pkg::ST_FILL_ACT;
              end
            end
          end
        end
        sdram_cache_pkg::ST_REFRESH: begin
          if (cmd_done) begin
            idle_cnt <= '0;
            state <= sdram_cache_pkg::ST_IDLE;
          end
        end
        sdram_cache_pkg::ST_EVICT_ACT: begin
          // row open, burst the victim line out
          if (cmd_done) begin
            sdrc_cmd_en <= 1'b1;
            sdrc_cmd <= sdram_cache_pkg::CMD_WRITE;
            sdrc_addr <= victim_addr;
            sdrc_data_len <= sdram_cache_pkg::BURST_LEN;
            col <= '0;
            state <= sdram_cache_pkg::ST_EVICT_STREAM;
          end
        end
        sdram_cache_pkg::ST_EVICT_STREAM: begin
          col <= col + 1'b1;
          if (col == sdram_cache_pkg::COL_BITS'(sdram_cache_pkg::COL_COUNT - 1)) begin
            state <= sdram_cache_pkg::ST_EVICT_DONE;
          end
        end
        sdram_cache_pkg::ST_EVICT_DONE: begin
          // write acked, open the row of the missing line
          if (cmd_done) begin
            sdrc_cmd_en <= 1'b1;
            sdrc_cmd <= sdram_cache_pkg::CMD_ACTIVATE;
            sdrc_addr <= fill_addr;
            sdrc_data_len <= '0;
            state <= sdram_cache_pkg::ST_FILL_ACT;
          end
        end
        sdram_cache_pkg::ST_FILL_ACT: begin
          if (cmd_done) begin
            sdrc_cmd_en <= 1'b1;
            sdrc_cmd <= sdram_cache_pkg::CMD_READ;
            sdrc_addr <= fill_addr;
            sdrc_data_len <= sdram_cache_pkg::BURST_LEN;
            wait_cnt <= '0;
            state <= sdram_cache_pkg::ST_FILL_WAIT;
          end
        end
        sdram_cache_pkg::ST_FILL_WAIT: begin
          // entered in the read command cycle
          wait_cnt <= wait_cnt + 1'b1;
          if (wait_cnt == sdram_cache_pkg::READ_WAIT) begin
            col <= '0;
            state <= sdram_cache_pkg::ST_FILL_STREAM;
          end
        end
        sdram_cache_pkg::ST_FILL_STREAM: begin
          col <= col + 1'b1;
          if (col == sdram_cache_pkg::COL_BITS'(sdram_cache_pkg::COL_COUNT - 1)) begin
            state <= sdram_cache_pkg::ST_TAG_COMMIT;
          end
        end
        sdram_cache_pkg::ST_TAG_COMMIT: begin
          // tag written this cycle, hit shows up next cycle
          state <= sdram_cache_pkg::ST_IDLE;
        end
        default: begin
          state <= sdram_cache_pkg::ST_IDLE;
        end
      endcase
    end
  end

  a_cmd_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    sdrc_cmd_en |=> !sdrc_cmd_en);

  // a new command only after the previous one was acked
  a_cmd_acked: assert property (@(posedge clk) disable iff (!rst_n)
    sdrc_cmd_en |-> !cmd_pending);

endmodule

`default_nettype wire

/* logic/sdram_cache.sv */
// direct mapped write-back cache in front of an sdram controller
// tag store and line store run on the same line index, the
// sequencer handles refresh, eviction and line fill
`timescale 1ns/1ps
`default_nettype none

module sdram_cache (
  input wire clk,
  input wire rst_n,
  input wire enable,
  input wire [31:0] address,
  input wire [31:0] data_in,
  input wire [3:0] write_enable,
  output logic [31:0] data_out,
  output logic data_out_ready,
  output logic busy,
  output logic sdrc_cmd_en,
  output logic [2:0] sdrc_cmd,
  output logic [sdram_cache_pkg::SDRAM_ADDR_BITS-1:0] sdrc_addr,
  output logic [7:0] sdrc_data_len,
  output logic [31:0] sdrc_data_in,
  input wire [31:0] sdrc_data_out,
  input wire sdrc_cmd_ack
);

  logic hit;
  logic line_dirty;
  logic [sdram_cache_pkg::TAG_BITS-1:0] cached_tag;
  logic cpu_write_hit;
  logic filling;
  logic [sdram_cache_pkg::COL_COUNT-1:0] fill_col_we;
  logic [31:0] fill_word;
  logic tag_fill_we;
  logic [sdram_cache_pkg::COL_BITS-1:0] evict_col;
  logic [31:0] evict_word;

  tag_store u_tag_store (
    .clk(clk),
    .enable(enable),
    .address(address),
    .write_enable(write_enable),
    .filling(filling),
    .tag_fill_we(tag_fill_we),
    .hit(hit),
    .line_dirty(line_dirty),
    .cached_tag(cached_tag),
    .cpu_write_hit(cpu_write_hit),
    .busy(busy),
    .data_out_ready(data_out_ready)
  );

  line_store u_line_store (
    .clk(clk),
    .address(address),
    .data_in(data_in),
    .write_enable(write_enable),
    .cpu_write_hit(cpu_write_hit),
    .filling(filling),
    .fill_col_we(fill_col_we),
    .fill_word(fill_word),
    .evict_col(evict_col),
    .data_out(data_out),
    .evict_word(evict_word)
  );

  sdram_seq u_sdram_seq (
    .clk(clk),
    .rst_n(rst_n),
    .enable(enable),
    .address(address),
    .hit(hit),
    .line_dirty(line_dirty),
    .cached_tag(cached_tag),
    .evict_word(evict_word),
    .sdrc_data_out(sdrc_data_out),
    .sdrc_cmd_ack(sdrc_cmd_ack),
    .filling(filling),
    .fill_col_we(fill_col_we),
    .fill_word(fill_word),
    .tag_fill_we(tag_fill_we),
    .evict_col(evict_col),
    .sdrc_cmd_en(sdrc_cmd_en),
    .sdrc_cmd(sdrc_cmd),
    .sdrc_addr(sdrc_addr),
    .sdrc_data_len(sdrc_data_len),
    .sdrc_data_in(sdrc_data_in)
  );

endmodule

`default_nettype wire

/* tb/sdram_model.sv */
// behavioral sdram controller for the cache testbench
// acks each command a fixed number of cycles later, captures write
// bursts, returns read bursts after the read wait, checks the protocol
`timescale 1ns/1ps
`default_nettype none

module sdram_model #(
  parameter logic [31:0] MEM_XOR = 32'h0
) (
  input wire clk,
  input wire rst_n,
  input wire cmd_en,
  input wire [2:0] cmd,
  input wire [20:0] addr,
  input wire [7:0] data_len,
  input wire [31:0] data_in,
  output logic [31:0] data_out,
  output logic cmd_ack,
  output int write_cmds,
  output int protocol_errors
);

  localparam int MEM_WORDS = 4096;
  localparam int RD_FIRST = int'(sdram_cache_pkg::READ_WAIT);
  localparam int LAST_COL = sdram_cache_pkg::COL_COUNT - 1;

  // indexed by the low 12 word address bits
  // testbench addresses stay below 4096
  logic [31:0] mem [MEM_WORDS];
  logic [1:0] ack_cnt;
  logic outstanding;
  logic prev_cmd_en;
  logic wr_active;
  logic [2:0] wr_idx;
  logic [11:0] wr_base;
  logic rd_active;
  int rd_step;
  logic [11:0] rd_base;

  initial begin
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem[i] = 32'(i) ^ MEM_XOR;
    end
  end

  always @(posedge clk) begin
    if (!rst_n) begin
      data_out <= '0;
      cmd_ack <= 1'b0;
      write_cmds <= 0;
      protocol_errors <= 0;
      ack_cnt <= '0;
      outstanding <= 1'b0;
      prev_cmd_en <= 1'b0;
      wr_active <= 1'b0;
      rd_active <= 1'b0;
    end else begin
      cmd_ack <= 1'b0;
      prev_cmd_en <= cmd_en;
      // ack lands 3 cycles after the command cycle
      if (ack_cnt != 2'd0) begin
        ack_cnt <= ack_cnt - 2'd1;
        if (ack_cnt == 2'd1) begin
          cmd_ack <= 1'b1;
        end
      end
      if (cmd_ack) begin
        outstanding <= 1'b0;
      end
      // columns 1 to 7 of a write burst
      if (wr_active) begin
        mem[wr_base + {9'd0, wr_idx}] <= data_in;
        wr_idx <= wr_idx + 3'd1;
        if (wr_idx == 3'(LAST_COL)) begin
          wr_active <= 1'b0;
        end
      end
      // word k goes out READ_WAIT+1+k cycles after the read command
      if (rd_active) begin
        rd_step <= rd_step + 1;
        if (rd_step >= RD_FIRST && rd_step <= RD_FIRST + LAST_COL) begin
          data_out <= mem[rd_base + 12'(rd_step - RD_FIRST)];
        end
        if (rd_step == RD_FIRST + LAST_COL) begin
          rd_active <= 1'b0;
        end
      end
      if (cmd_en) begin
        if (prev_cmd_en) begin
          $display("sdram model: cmd_en high two cycles in a row at %0t", $time);
          protocol_errors <= protocol_errors + 1;
        end else if (outstanding) begin
          $display("sdram model: command issued before the previous ack at %0t", $time);
          protocol_errors <= protocol_errors + 1;
        end
        outstanding <= 1'b1;
        ack_cnt <= 2'd2;
        if ((cmd == sdram_cache_pkg::CMD_WRITE || cmd == sdram_cache_pkg::CMD_READ) &&
            data_len != 8'(LAST_COL)) begin
          $display("sdram model: burst length %0d is not a full line at %0t",
                   data_len, $time);
          protocol_errors <= protocol_errors + 1;
        end
        if (cmd == sdram_cache_pkg::CMD_WRITE) begin
          // column 0 rides along with the write command
          write_cmds <= write_cmds + 1;
          mem[addr[11:0]] <= data_in;
          wr_active <= 1'b1;
          wr_idx <= 3'd1;
          wr_base <= addr[11:0];
        end else if (cmd == sdram_cache_pkg::CMD_READ) begin
          rd_active <= 1'b1;
          rd_step <= 1;
          rd_base <= addr[11:0];
        end
      end
    end
  end

endmodule

`default_nettype wire

/* tb/tb_sdram_cache.sv */
// testbench for the sdram cache
// clean misses, a directed dirty eviction, random reads and masked
// writes against a flat reference memory, then an idle refresh phase
`timescale 1ns/1ps
`default_nettype none

module tb_sdram_cache;

  localparam logic [31:0] MEM_XOR = 32'h5a3c_0000;
  localparam int CLEAN_READS = 24;
  localparam int EVICT_OPS = 4;
  localparam int NUM_OPS = 400;
  localparam int RAND_ITERS = (NUM_OPS - CLEAN_READS - EVICT_OPS) / 2;
  localparam int CYCLES_PER_OP = 60;
  localparam int IDLE_CYCLES = 1000;
  localparam int TIMEOUT_CYCLES = NUM_OPS * CYCLES_PER_OP + IDLE_CYCLES;
  localparam int REFRESH_GAP = int'(sdram_cache_pkg::REFRESH_PERIOD) + 8;

  logic clk;
  logic rst_n;
  logic enable;
  logic [31:0] address;
  logic [31:0] data_in;
  logic [3:0] write_enable;
  logic [31:0] data_out;
  logic data_out_ready;
  logic busy;
  logic sdrc_cmd_en;
  logic [2:0] sdrc_cmd;
  logic [20:0] sdrc_addr;
  logic [7:0] sdrc_data_len;
  logic [31:0] sdrc_data_in;
  logic [31:0] sdrc_data_out;
  logic sdrc_cmd_ack;
  int write_cmds;
  int protocol_errors;

  // reference memory with the model's initial contents
  logic [31:0] ref_mem [4096];
  logic [31:0] rng = 32'd48;
  int errors = 0;
  int monitor_errors = 0;
  int access_count = 0;
  int cycle = 0;
  int last_refresh = 0;
  int idle_start = 0;
  int idle_refreshes = 0;
  logic idle_phase = 1'b0;
  logic seen_cmd = 1'b0;

  sdram_cache DUT (
    .clk(clk),
    .rst_n(rst_n),
    .enable(enable),
    .address(address),
    .data_in(data_in),
    .write_enable(write_enable),
    .data_out(data_out),
    .data_out_ready(data_out_ready),
    .busy(busy),
    .sdrc_cmd_en(sdrc_cmd_en),
    .sdrc_cmd(sdrc_cmd),
    .sdrc_addr(sdrc_addr),
    .sdrc_data_len(sdrc_data_len),
    .sdrc_data_in(sdrc_data_in),
    .sdrc_data_out(sdrc_data_out),
    .sdrc_cmd_ack(sdrc_cmd_ack)
  );

  sdram_model #(.MEM_XOR(MEM_XOR)) u_sdram_model (
    .clk(clk),
    .rst_n(rst_n),
    .cmd_en(sdrc_cmd_en),
    .cmd(sdrc_cmd),
    .addr(sdrc_addr),
    .data_len(sdrc_data_len),
    .data_in(sdrc_data_in),
    .data_out(sdrc_data_out),
    .cmd_ack(sdrc_cmd_ack),
    .write_cmds(write_cmds),
    .protocol_errors(protocol_errors)
  );

  always #2 clk = ~clk;

  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // 4 tags by 4 lines (0, 21, 42, 63) by 8 columns
  function automatic logic [31:0] make_addr(input logic [1:0] tag_sel,
                                            input logic [1:0] line_sel,
                                            input logic [2:0] col);
    logic [5:0] line;
    line = 6'd21 * {4'd0, line_sel};
    return {9'd0, 10'd0, tag_sel, line, col, 2'b00};
  endfunction

  task automatic print_counts;
    $display("errors: %0d check, %0d monitor, %0d protocol; %0d accesses, %0d sdram writes",
             errors, monitor_errors, protocol_errors, access_count, write_cmds);
  endtask

  task automatic check_word(input string name, input logic [31:0] addr,
                            input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
      $display("MISMATCH %s addr %08h expected %08h actual %08h", name, addr, exp, act);
      errors++;
    end
  endtask

  // called and returning 1 ns after a rising edge
  task automatic cpu_access(input logic [31:0] addr, input logic [31:0] wdata,
                            input logic [3:0] mask, output logic [31:0] rdata);
    enable = 1'b1;
    address = addr;
    data_in = wdata;
    write_enable = mask;
    // sample late in the cycle
    #2;
    while (busy) begin
      @(posedge clk);
      #3;
    end
    // with busy low a write lands on the coming edge
    if (mask == 4'b0000 && !data_out_ready) begin
      $display("read of %08h finished without data_out_ready", addr);
      errors++;
    end
    rdata = data_out;
    access_count++;
    @(posedge clk);
    #1;
  endtask

  task automatic read_check(input string name, input logic [31:0] addr);
    logic [31:0] got;
    cpu_access(addr, 32'd0, 4'b0000, got);
    check_word(name, addr, ref_mem[addr[13:2]], got);
  endtask

  task automatic write_word(input logic [31:0] addr, input logic [31:0] wdata,
                            input logic [3:0] mask);
    logic [31:0] ignored;
    cpu_access(addr, wdata, mask, ignored);
    for (int b = 0; b < 4; b++) begin
      if (mask[b]) begin
        ref_mem[addr[13:2]][8*b+:8] = wdata[8*b+:8];
      end
    end
  endtask

  // command monitor, refresh spacing and the timeout
  always @(posedge clk) begin
    cycle <= cycle + 1;
    if (rst_n && sdrc_cmd_en) begin
      seen_cmd <= 1'b1;
      if (!seen_cmd && sdrc_cmd != sdram_cache_pkg::CMD_REFRESH) begin
        $display("first command after reset is %03b, not a refresh", sdrc_cmd);
        monitor_errors++;
      end
      if (sdrc_cmd == sdram_cache_pkg::CMD_REFRESH) begin
        if (idle_phase) begin
          idle_refreshes <= idle_refreshes + 1;
          if (cycle - ((last_refresh > idle_start) ? last_refresh : idle_start) > REFRESH_GAP) begin
            $display("refresh gap too long at cycle %0d", cycle);
            monitor_errors++;
          end
        end
        last_refresh <= cycle;
      end
    end
    if (cycle >= TIMEOUT_CYCLES) begin
      $display("timeout, run still going after %0d cycles", TIMEOUT_CYCLES);
      print_counts();
      $display("TESTS FAILED");
      $finish;
    end
  end

  initial begin
    logic [31:0] addr;
    logic [3:0] mask;
    int wr_before;
    clk = 1'b0;
    rst_n = 1'b0;
    enable = 1'b0;
    address = '0;
    data_in = '0;
    write_enable = '0;
    for (int i = 0; i < 4096; i++) begin
      ref_mem[i] = 32'(i) ^ MEM_XOR;
    end
    repeat (2) @(posedge clk);
    #1;
    rst_n = 1'b1;

    // reads only on conflicting tags while nothing is dirty yet
    wr_before = write_cmds;
    for (int i = 0; i < CLEAN_READS; i++) begin
      rng = lcg_step(rng);
      read_check("clean_miss", make_addr(rng[31:30], rng[29:28], rng[27:25]));
    end
    if (write_cmds != wr_before) begin
      $display("clean misses issued %0d sdram write commands", write_cmds - wr_before);
      errors++;
    end

    // dirty line 21 under tag 0 and evict it with tag 1
    addr = make_addr(2'd0, 2'd1, 3'd5);
    rng = lcg_step(rng);
    write_word(addr, rng, 4'b0110);
    read_check("evict", addr);
    wr_before = write_cmds;
    read_check("evict", make_addr(2'd1, 2'd1, 3'd2));
    if (write_cmds == wr_before) begin
      $display("conflicting read did not write back the dirty line");
      errors++;
    end
    for (int c = 0; c < 8; c++) begin
      addr = make_addr(2'd0, 2'd1, 3'(c));
      check_word("model_line", addr, ref_mem[addr[13:2]], u_sdram_model.mem[addr[13:2]]);
    end
    read_check("evict", make_addr(2'd0, 2'd1, 3'd5));

    // random traffic where every write is read back at once
    for (int i = 0; i < RAND_ITERS; i++) begin
      rng = lcg_step(rng);
      addr = make_addr(rng[31:30], rng[29:28], rng[27:25]);
      if (rng[24]) begin
        mask = (rng[23:20] == 4'b0000) ? 4'b0001 : rng[23:20];
        rng = lcg_step(rng);
        write_word(addr, rng, mask);
        read_check("write_readback", addr);
      end else begin
        read_check("random_read", addr);
      end
    end

    // idle phase with only refreshes running
    enable = 1'b0;
    write_enable = 4'b0000;
    idle_start = cycle;
    idle_phase = 1'b1;
    repeat (IDLE_CYCLES) @(posedge clk);
    #1;
    idle_phase = 1'b0;
    if (idle_refreshes == 0) begin
      $display("no refresh during %0d idle cycles", IDLE_CYCLES);
      errors++;
    end
    if (cycle - ((last_refresh > idle_start) ? last_refresh : idle_start) > REFRESH_GAP) begin
      $display("refresh stopped near the end of the idle phase");
      errors++;
    end

    print_counts();
    if (errors + monitor_errors + protocol_errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* sdram_cache.f */
common/sdram_cache_pkg.sv
logic/bram_byte.sv
logic/tag_store.sv
logic/line_store.sv
sdram_seq/sdram_seq.sv
logic/sdram_cache.sv
tb/sdram_model.sv
tb/tb_sdram_cache.sv

/* Makefile */
# Verilator build and run for the sdram cache testbench

VERILATOR ?= verilator
TOP ?= tb_sdram_cache
FILELIST ?= sdram_cache.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert --timescale 1ns/1ps
PASS_TEXT ?= TESTS PASSED

SIM = $(BUILD_DIR)/V$(TOP)
SOURCES = $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
